/* compile.f */
src/wb_pkg.sv
src/wbm_spi.sv
src/wbx_1master.sv
src/wbs_rgb.sv
src/wbs_ram.sv
src/spi_wb_top.sv
dv/wb_checker.sv
dv/tb_top.sv

/* run.sh */
#!/bin/sh
# build and run the SPI to Wishbone testbench with Verilator

cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_top \
	-Mdir "$OBJ_DIR" -o tb_top \
	-f compile.f
status=$?
if [ $status -ne 0 ]; then
	echo "build failed with status $status"
	exit 1
fi

"./$OBJ_DIR/tb_top" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qxF '** PASS **' "$LOG"; then
	echo "test passed"
	exit 0
else
	echo "test failed, see $LOG"
	exit 1
fi

/* dv/tb_top.sv */
`timescale 1ns/10ps

module tb_top;
	localparam int PERIPH_NUM = 2;
	localparam int PWM_PRESCALE = 1;
	// upper bound on spi frames, a read frame takes a bit over 520 cycles
	localparam int N_FRAMES = 120;
	localparam int TIMEOUT = N_FRAMES * 600 + 2 * 256 * PWM_PRESCALE;

	logic clk;
	logic reset_i;
	logic spi_sck;
	logic spi_csn;
	logic spi_sdi;
	logic spi_sdo;
	logic led_r;
	logic led_g;
	logic led_b;

	int seed;
	int cyc_cnt = 0;
	int req_cnt = 0;
	int n0;
	logic [31:0] rnd;
	logic [15:0] adr;
	logic [63:0] rx;
	logic [31:0] got_w;
	logic [31:0] exp_w;
	// reference copy of the ram and the rgb registers
	logic [31:0] ram_m [16];
	logic [7:0] rgb_m [4];
	logic [31:0] act_q [$];
	logic [31:0] exp_q [$];

	spi_wb_top #(
		.PERIPH_NUM(PERIPH_NUM),
		.PWM_PRESCALE(PWM_PRESCALE)
	) i_dut (
		.clk(clk),
		.reset_i(reset_i),
		.spi_sck_i(spi_sck),
		.spi_csn_i(spi_csn),
		.spi_sdi_i(spi_sdi),
		.spi_sdo_o(spi_sdo),
		.led_r_o(led_r),
		.led_g_o(led_g),
		.led_b_o(led_b)
	);

	bind wbm_spi wb_checker u_wb_checker (
		.clk(clk),
		.reset_i(reset_i),
		.cyc_i(wbm_cyc_o),
		.stb_i(wbm_stb_o),
		.stall_i(wbm_stall_i),
		.ack_i(wbm_ack_i)
	);

	always #4 clk = ~clk;

	task automatic fail_stop(input string why);
		$display("%s", why);
		$display("** FAIL **");
		$fatal(1, "run stopped on first error");
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERR t=%0t %s expected %h got %h", $time, name, exp, got);
			fail_stop("value mismatch");
		end
	endtask

	// expected read data from the address map
	function automatic logic [31:0] ref_read(input logic [15:0] a);
		if (a[15:8] != 8'h00) begin
			return 32'h0;
		end
		if (a[7:4] == 4'(wb_pkg::PERIPH_RAM)) begin
			return ram_m[a[3:0]];
		end
		if (a[7:4] == 4'(wb_pkg::PERIPH_RGB) && a[3:0] < 4'd4) begin
			return {24'h0, rgb_m[a[1:0]]};
		end
		return 32'h0;
	endfunction

	function automatic void model_write(input logic [15:0] a, input logic [31:0] d);
		if (a[15:8] == 8'h00 && a[7:4] == 4'(wb_pkg::PERIPH_RAM)) begin
			ram_m[a[3:0]] = d;
		end else if (a[15:8] == 8'h00 && a[7:4] == 4'(wb_pkg::PERIPH_RGB) && a[3:0] < 4'd4) begin
			// ctrl keeps only its enable bit
			rgb_m[a[1:0]] = (a[3:0] == wb_pkg::RGB_REG_CTRL) ? {7'h0, d[0]} : d[7:0];
		end
	endfunction

	task automatic wait_clk(input int n);
		repeat (n) @(posedge clk);
		#1;
	endtask

	// mode 0, msb first, sck high and low for 4 clk each
	task automatic spi_xfer(input int nbits, input logic [63:0] tx, output logic [63:0] rx_o);
		rx_o = '0;
		spi_csn = 1'b0;
		wait_clk(4);
		for (int i = nbits - 1; i >= 0; i--) begin
			spi_sdi = tx[i];
			wait_clk(4);
			rx_o[i] = spi_sdo;
			spi_sck = 1'b1;
			wait_clk(4);
			spi_sck = 1'b0;
		end
		spi_sdi = 1'b0;
		wait_clk(4);
		spi_csn = 1'b1;
	endtask

	// exactly one bus cycle per full frame, then the bus goes idle
	task automatic finish_frame(input int start);
		wait (req_cnt != start && !i_dut.wbm_cyc);
		wait_clk(2);
		check("bus requests per frame", 32'(req_cnt - start), 32'd1);
	endtask

	task automatic spi_write(input logic [15:0] a, input logic [31:0] d);
		logic [6:0] junk;
		logic [63:0] frame_rx;
		int start;
		junk = 7'($random(seed));
		start = req_cnt;
		spi_xfer(56, {8'h00, 1'b1, junk, a, d}, frame_rx);
		finish_frame(start);
		model_write(a, d);
	endtask

	task automatic spi_read(input logic [15:0] a);
		logic [6:0] junk;
		logic [63:0] frame_rx;
		int start;
		junk = 7'($random(seed));
		start = req_cnt;
		spi_xfer(64, {1'b0, junk, a, 8'h00, 32'h0}, frame_rx);
		finish_frame(start);
		// sdo stays low through command, address and dummy byte
		check("spi_sdo_o before data phase", frame_rx[63:32], 32'h0);
		exp_q.push_back(ref_read(a));
		act_q.push_back(frame_rx[31:0]);
	endtask

	// one full pwm period, any window of this length gives exact counts
	task automatic pwm_window();
		int high_r;
		int high_g;
		int high_b;
		int en;
		high_r = 0;
		high_g = 0;
		high_b = 0;
		en = int'(rgb_m[3][0]);
		repeat (256 * PWM_PRESCALE) begin
			wait_clk(1);
			high_r += int'(led_r);
			high_g += int'(led_g);
			high_b += int'(led_b);
		end
		check("led_r_o high cycles", high_r, en * rgb_m[0] * PWM_PRESCALE);
		check("led_g_o high cycles", high_g, en * rgb_m[1] * PWM_PRESCALE);
		check("led_b_o high cycles", high_b, en * rgb_m[2] * PWM_PRESCALE);
	endtask

	always @(posedge clk) begin
		cyc_cnt++;
		if (cyc_cnt > TIMEOUT) begin
			fail_stop($sformatf("timeout, test still running after %0d cycles", TIMEOUT));
		end
	end

	// accepted requests on the master bus
	always @(posedge clk) begin
		if (!reset_i && i_dut.wbm_stb && !i_dut.wbm_stall) begin
			req_cnt++;
		end
	end

	always @(posedge clk) begin
		if (act_q.size() != 0) begin
			got_w = act_q.pop_front();
			exp_w = exp_q.pop_front();
			check("spi_sdo_o read word", got_w, exp_w);
		end
	end

	initial begin
		seed = 34336;
		clk = 1'b0;
		reset_i = 1'b1;
		spi_sck = 1'b0;
		spi_csn = 1'b1;
		spi_sdi = 1'b0;
		for (int i = 0; i < 4; i++) begin
			rgb_m[i] = 8'h00;
		end
		repeat (4) @(posedge clk);
		#1;
		reset_i = 1'b0;
		wait_clk(4);

		// ram is not reset, give every word a known value
		for (int a = 0; a < 16; a++) begin
			spi_write(16'(16 + a), $random(seed));
		end

		// random write and read pairs in ram
		repeat (20) begin
			rnd = $random(seed);
			adr = {12'h001, rnd[3:0]};
			spi_write(adr, $random(seed));
			spi_read(adr);
		end

		// rgb registers and the unused offsets
		for (int a = 0; a < 4; a++) begin
			spi_write(16'(a), $random(seed));
		end
		for (int a = 0; a < 16; a++) begin
			spi_read(16'(a));
		end

		// unmapped index, and high bits set over ram and rgb aliases
		for (int k = 0; k < 6; k++) begin
			rnd = $random(seed);
			case (k % 3)
				0: adr = {8'h00, 4'd2 + 4'(rnd[3:0] % 4'd14), rnd[7:4]};
				1: adr = {rnd[15:8] | 8'h01, 4'h1, rnd[3:0]};
				default: adr = {rnd[15:8] | 8'h80, 6'h00, rnd[1:0]};
			endcase
			spi_write(adr, $random(seed));
			spi_read(adr);
		end
		for (int a = 0; a < 16; a++) begin
			spi_read(16'(16 + a));
		end
		for (int a = 0; a < 4; a++) begin
			spi_read(16'(a));
		end

		// pwm with the outputs enabled, then disabled
		spi_write(16'(wb_pkg::RGB_REG_R), $random(seed));
		spi_write(16'(wb_pkg::RGB_REG_G), $random(seed));
		spi_write(16'(wb_pkg::RGB_REG_B), $random(seed));
		spi_write(16'(wb_pkg::RGB_REG_CTRL), 32'h1);
		pwm_window();
		spi_write(16'(wb_pkg::RGB_REG_CTRL), 32'h0);
		pwm_window();

		// csn rises in the middle of the address
		n0 = req_cnt;
		spi_xfer(16, {48'h0, 8'h00, 8'h00}, rx);
		wait_clk(16);
		check("bus requests after abort", 32'(req_cnt - n0), 32'd0);
		rnd = $random(seed);
		spi_read({12'h001, rnd[3:0]});

		while (act_q.size() != 0) begin
			wait_clk(1);
		end
		wait_clk(2);
		if (i_dut.u_wbm_spi.u_wb_checker.fail_cnt == 0) begin
			$display("** PASS **");
			$finish;
		end else begin
			fail_stop("assertion failures on the master bus");
		end
	end

endmodule

/* dv/wb_checker.sv */
`timescale 1ns/10ps

module wb_checker (
	input logic clk,
	input logic reset_i,
	input logic cyc_i,
	input logic stb_i,
	input logic stall_i,
	input logic ack_i
);
	int fail_cnt = 0;
	logic pending;

	// request in flight from acceptance until its ack
	always_ff @(posedge clk) begin
		if (reset_i) begin
			pending <= 1'b0;
		end else if (stb_i && !stall_i) begin
			pending <= 1'b1;
		end else if (ack_i) begin
			pending <= 1'b0;
		end
	end

	stb_needs_cyc: assert property (@(posedge clk) disable iff (reset_i) stb_i |-> cyc_i)
		else begin
			fail_cnt++;
			$error("stb high without cyc");
		end

	ack_needs_cyc: assert property (@(posedge clk) disable iff (reset_i) ack_i |-> cyc_i)
		else begin
			fail_cnt++;
			$error("ack while cyc is low");
		end

	// single outstanding request
	no_stb_pending: assert property (@(posedge clk) disable iff (reset_i) pending |-> !stb_i)
		else begin
			fail_cnt++;
			$error("new stb before the previous ack");
		end

endmodule

/* src/spi_wb_top.sv */
`timescale 1ns/10ps

module spi_wb_top #(
	parameter int unsigned PERIPH_NUM = 2,
	parameter int unsigned PWM_PRESCALE = 1
) (
	input  logic clk,
	input  logic reset_i,

	input  logic spi_sck_i,
	input  logic spi_csn_i,
	input  logic spi_sdi_i,
	output logic spi_sdo_o,

	output logic led_r_o,
	output logic led_g_o,
	output logic led_b_o
);
	localparam int unsigned DW = wb_pkg::WB_DAT_W;

	// master side
	logic wbm_cyc;
	logic wbm_stb;
	logic wbm_we;
	logic [wb_pkg::WB_ADR_W-1:0] wbm_adr;
	logic [wb_pkg::WB_SEL_W-1:0] wbm_sel;
	logic [DW-1:0] wbm_wdat;
	logic [DW-1:0] wbm_rdat;
	logic wbm_stall;
	logic wbm_ack;

	// shared slave side
	logic [PERIPH_NUM-1:0] wbs_cyc;
	logic wbs_stb;
	logic wbs_we;
	logic [wb_pkg::SLV_ADR_W-1:0] wbs_adr;
	logic [wb_pkg::WB_SEL_W-1:0] wbs_sel;
	logic [DW-1:0] wbs_wdat;
	logic [DW*PERIPH_NUM-1:0] wbs_rdat;
	logic [PERIPH_NUM-1:0] wbs_ack;

	wbm_spi u_wbm_spi (
		.clk(clk),
		.reset_i(reset_i),
		.spi_sck_i(spi_sck_i),
		.spi_csn_i(spi_csn_i),
		.spi_sdi_i(spi_sdi_i),
		.spi_sdo_o(spi_sdo_o),
		.wbm_cyc_o(wbm_cyc),
		.wbm_stb_o(wbm_stb),
		.wbm_we_o(wbm_we),
		.wbm_adr_o(wbm_adr),
		.wbm_sel_o(wbm_sel),
		.wbm_dat_o(wbm_wdat),
		.wbm_dat_i(wbm_rdat),
		.wbm_stall_i(wbm_stall),
		.wbm_ack_i(wbm_ack)
	);

	wbx_1master #(
		.PERIPH_NUM(PERIPH_NUM)
	) u_wbx_1master (
		.clk(clk),
		.reset_i(reset_i),
		.wbm_cyc_i(wbm_cyc),
		.wbm_stb_i(wbm_stb),
		.wbm_we_i(wbm_we),
		.wbm_adr_i(wbm_adr),
		.wbm_sel_i(wbm_sel),
		.wbm_dat_i(wbm_wdat),
		.wbm_dat_o(wbm_rdat),
		.wbm_stall_o(wbm_stall),
		.wbm_ack_o(wbm_ack),
		.wbs_cyc_o(wbs_cyc),
		.wbs_stb_o(wbs_stb),
		.wbs_we_o(wbs_we),
		.wbs_adr_o(wbs_adr),
		.wbs_sel_o(wbs_sel),
		.wbs_dat_o(wbs_wdat),
		.wbs_dat_i(wbs_rdat),
		.wbs_ack_i(wbs_ack)
	);

	wbs_rgb #(
		.PWM_PRESCALE(PWM_PRESCALE)
	) u_wbs_rgb (
		.clk(clk),
		.reset_i(reset_i),
		.wb_cyc_i(wbs_cyc[wb_pkg::PERIPH_RGB]),
		.wb_stb_i(wbs_stb),
		.wb_we_i(wbs_we),
		.wb_adr_i(wbs_adr),
		.wb_sel_i(wbs_sel),
		.wb_dat_i(wbs_wdat),
		.wb_dat_o(wbs_rdat[wb_pkg::PERIPH_RGB*DW +: DW]),
		.wb_ack_o(wbs_ack[wb_pkg::PERIPH_RGB]),
		.led_r_o(led_r_o),
		.led_g_o(led_g_o),
		.led_b_o(led_b_o)
	);

	wbs_ram u_wbs_ram (
		.clk(clk),
		.reset_i(reset_i),
		.wb_cyc_i(wbs_cyc[wb_pkg::PERIPH_RAM]),
		.wb_stb_i(wbs_stb),
		.wb_we_i(wbs_we),
		.wb_adr_i(wbs_adr),
		.wb_sel_i(wbs_sel),
		.wb_dat_i(wbs_wdat),
		.wb_dat_o(wbs_rdat[wb_pkg::PERIPH_RAM*DW +: DW]),
		.wb_ack_o(wbs_ack[wb_pkg::PERIPH_RAM])
	);

endmodule

/* src/wbs_ram.sv */
`timescale 1ns/10ps

module wbs_ram (
	input  logic clk,
	input  logic reset_i,

	input  logic wb_cyc_i,
	input  logic wb_stb_i,
	input  logic wb_we_i,
	input  logic [wb_pkg::SLV_ADR_W-1:0] wb_adr_i,
	input  logic [wb_pkg::WB_SEL_W-1:0] wb_sel_i,
	input  logic [wb_pkg::WB_DAT_W-1:0] wb_dat_i,
	output logic [wb_pkg::WB_DAT_W-1:0] wb_dat_o,
	output logic wb_ack_o
);
	localparam int unsigned DEPTH = 1 << wb_pkg::SLV_ADR_W;

	logic access;
	logic [wb_pkg::WB_DAT_W-1:0] mem [DEPTH];

	assign access = wb_cyc_i & wb_stb_i;

	always_ff @(posedge clk) begin
		if (reset_i) begin
			wb_ack_o <= 1'b0;
		end else begin
			wb_ack_o <= access;
		end
	end

	// byte lanes written under their select bits
	always_ff @(posedge clk) begin
		if (access) begin
			if (wb_we_i) begin
				for (int b = 0; b < wb_pkg::WB_SEL_W; b++) begin
					if (wb_sel_i[b]) begin
						mem[wb_adr_i][8*b +: 8] <= wb_dat_i[8*b +: 8];
					end
				end
			end
			wb_dat_o <= mem[wb_adr_i];
		end
	end

endmodule

/* src/wbs_rgb.sv */
`timescale 1ns/10ps

module wbs_rgb #(
	parameter int unsigned PWM_PRESCALE = 1
) (
	input  logic clk,
	input  logic reset_i,

	input  logic wb_cyc_i,
	input  logic wb_stb_i,
	input  logic wb_we_i,
	input  logic [wb_pkg::SLV_ADR_W-1:0] wb_adr_i,
	input  logic [wb_pkg::WB_SEL_W-1:0] wb_sel_i,
	input  logic [wb_pkg::WB_DAT_W-1:0] wb_dat_i,
	output logic [wb_pkg::WB_DAT_W-1:0] wb_dat_o,
	output logic wb_ack_o,

	output logic led_r_o,
	output logic led_g_o,
	output logic led_b_o
);
	localparam int unsigned PRE_W = $clog2(PWM_PRESCALE + 1);

	logic access;
	logic [7:0] duty_r;
	logic [7:0] duty_g;
	logic [7:0] duty_b;
	logic enable;
	logic [PRE_W-1:0] pre_cnt;
	logic pwm_tick;
	logic [7:0] pwm_cnt;

	assign access = wb_cyc_i & wb_stb_i;

	always_ff @(posedge clk) begin
		if (reset_i) begin
			wb_ack_o <= 1'b0;
			duty_r <= '0;
			duty_g <= '0;
			duty_b <= '0;
			enable <= 1'b0;
		end else begin
			wb_ack_o <= access;
			// all registers live in byte lane 0
			if (access && wb_we_i && wb_sel_i[0]) begin
				case (wb_adr_i)
					wb_pkg::RGB_REG_R: duty_r <= wb_dat_i[7:0];
					wb_pkg::RGB_REG_G: duty_g <= wb_dat_i[7:0];
					wb_pkg::RGB_REG_B: duty_b <= wb_dat_i[7:0];
					wb_pkg::RGB_REG_CTRL: enable <= wb_dat_i[0];
					default: ;
				endcase
			end
		end
	end

	// read data, zero-extended
	always_ff @(posedge clk) begin
		if (access) begin
			wb_dat_o <= '0;
			case (wb_adr_i)
				wb_pkg::RGB_REG_R: wb_dat_o[7:0] <= duty_r;
				wb_pkg::RGB_REG_G: wb_dat_o[7:0] <= duty_g;
				wb_pkg::RGB_REG_B: wb_dat_o[7:0] <= duty_b;
				wb_pkg::RGB_REG_CTRL: wb_dat_o[0] <= enable;
				default: ;
			endcase
		end
	end

	assign pwm_tick = pre_cnt == PRE_W'(PWM_PRESCALE - 1);

	// prescaler and free-running pwm counter
	always_ff @(posedge clk) begin
		if (reset_i) begin
			pre_cnt <= '0;
			pwm_cnt <= '0;
		end else if (pwm_tick) begin
			pre_cnt <= '0;
			pwm_cnt <= pwm_cnt + 1'b1;
		end else begin
			pre_cnt <= pre_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			led_r_o <= 1'b0;
			led_g_o <= 1'b0;
			led_b_o <= 1'b0;
		end else begin
			led_r_o <= enable && pwm_cnt < duty_r;
			led_g_o <= enable && pwm_cnt < duty_g;
			led_b_o <= enable && pwm_cnt < duty_b;
		end
	end

endmodule

/* src/wbx_1master.sv */
`timescale 1ns/10ps

module wbx_1master #(
	parameter int unsigned PERIPH_NUM = 2
) (
	input  logic clk,
	input  logic reset_i,

	input  logic wbm_cyc_i,
	input  logic wbm_stb_i,
	input  logic wbm_we_i,
	input  logic [wb_pkg::WB_ADR_W-1:0] wbm_adr_i,
	input  logic [wb_pkg::WB_SEL_W-1:0] wbm_sel_i,
	input  logic [wb_pkg::WB_DAT_W-1:0] wbm_dat_i,
	output logic [wb_pkg::WB_DAT_W-1:0] wbm_dat_o,
	output logic wbm_stall_o,
	output logic wbm_ack_o,

	output logic [PERIPH_NUM-1:0] wbs_cyc_o,
	output logic wbs_stb_o,
	output logic wbs_we_o,
	output logic [wb_pkg::SLV_ADR_W-1:0] wbs_adr_o,
	output logic [wb_pkg::WB_SEL_W-1:0] wbs_sel_o,
	output logic [wb_pkg::WB_DAT_W-1:0] wbs_dat_o,
	input  logic [wb_pkg::WB_DAT_W*PERIPH_NUM-1:0] wbs_dat_i,
	input  logic [PERIPH_NUM-1:0] wbs_ack_i
);
	localparam int unsigned IDX_W = 4;
	localparam int unsigned HIGH_LSB = wb_pkg::PERIPH_LSB + IDX_W;

	logic accept;
	logic [IDX_W-1:0] req_idx;
	logic req_mapped;
	logic busy;
	logic miss_ack;
	logic [IDX_W-1:0] idx_q;

	assign accept = wbm_cyc_i & wbm_stb_i & ~busy;
	assign req_idx = wbm_adr_i[wb_pkg::PERIPH_LSB +: IDX_W];
	assign req_mapped = (wbm_adr_i[wb_pkg::WB_ADR_W-1:HIGH_LSB] == '0) &&
		(req_idx < PERIPH_NUM);

	assign wbm_stall_o = busy;
	assign wbm_ack_o = miss_ack | (|(wbs_ack_i & wbs_cyc_o));
	// unmapped reads return zero
	assign wbm_dat_o = miss_ack ? '0 : wbs_dat_i[idx_q*wb_pkg::WB_DAT_W +: wb_pkg::WB_DAT_W];

	always_ff @(posedge clk) begin
		if (reset_i) begin
			busy <= 1'b0;
			miss_ack <= 1'b0;
			wbs_stb_o <= 1'b0;
			wbs_cyc_o <= '0;
		end else if (accept) begin
			busy <= 1'b1;
			miss_ack <= !req_mapped;
			wbs_stb_o <= req_mapped;
			for (int i = 0; i < PERIPH_NUM; i++) begin
				wbs_cyc_o[i] <= req_mapped && req_idx == i;
			end
		end else begin
			wbs_stb_o <= 1'b0;
			miss_ack <= 1'b0;
			if (wbm_ack_o) begin
				busy <= 1'b0;
				wbs_cyc_o <= '0;
			end
		end
	end

	// request payload toward the slaves
	always_ff @(posedge clk) begin
		if (accept) begin
			wbs_we_o <= wbm_we_i;
			wbs_adr_o <= wbm_adr_i[wb_pkg::SLV_ADR_W-1:0];
			wbs_sel_o <= wbm_sel_i;
			wbs_dat_o <= wbm_dat_i;
			if (req_mapped) begin
				idx_q <= req_idx;
			end
		end
	end

endmodule

/* src/wbm_spi.sv */
`timescale 1ns/10ps

module wbm_spi (
	input  logic clk,
	input  logic reset_i,

	input  logic spi_sck_i,
	input  logic spi_csn_i,
	input  logic spi_sdi_i,
	output logic spi_sdo_o,

	output logic wbm_cyc_o,
	output logic wbm_stb_o,
	output logic wbm_we_o,
	output logic [wb_pkg::WB_ADR_W-1:0] wbm_adr_o,
	output logic [wb_pkg::WB_SEL_W-1:0] wbm_sel_o,
	output logic [wb_pkg::WB_DAT_W-1:0] wbm_dat_o,
	input  logic [wb_pkg::WB_DAT_W-1:0] wbm_dat_i,
	input  logic wbm_stall_i,
	input  logic wbm_ack_i
);
	localparam int unsigned CNT_W = 7;
	localparam int unsigned CMD_BITS = 8;
	localparam int unsigned DUMMY_BITS = 8;

	// bit positions within a frame, counted from zero
	localparam int unsigned CMD_LAST = CMD_BITS - 1;
	localparam int unsigned ADR_LAST = CMD_BITS + wb_pkg::WB_ADR_W - 1;
	localparam int unsigned DAT_LAST = CMD_BITS + wb_pkg::WB_ADR_W + wb_pkg::WB_DAT_W - 1;
	localparam int unsigned RD_FIRST = CMD_BITS + wb_pkg::WB_ADR_W + DUMMY_BITS;
	localparam int unsigned FRAME_END = RD_FIRST + wb_pkg::WB_DAT_W;

	logic [2:0] sck_sync;
	logic [1:0] csn_sync;
	logic [1:0] sdi_sync;
	logic sck_rise;
	logic sck_fall;
	logic frame_off;
	logic [CNT_W-1:0] bit_cnt;
	logic [wb_pkg::WB_DAT_W-1:0] shift_in;
	logic [wb_pkg::WB_DAT_W-1:0] shift_next;
	logic [wb_pkg::WB_DAT_W-1:0] shift_out;
	logic is_write;
	logic issue_rd;
	logic issue_wr;
	logic data_phase;

	// two-flop synchronizers, sck keeps one more stage for edges
	always_ff @(posedge clk) begin
		if (reset_i) begin
			sck_sync <= '0;
			csn_sync <= '1;
			sdi_sync <= '0;
		end else begin
			sck_sync <= {sck_sync[1:0], spi_sck_i};
			csn_sync <= {csn_sync[0], spi_csn_i};
			sdi_sync <= {sdi_sync[0], spi_sdi_i};
		end
	end

	assign sck_rise = sck_sync[1] & ~sck_sync[2];
	assign sck_fall = ~sck_sync[1] & sck_sync[2];
	assign frame_off = csn_sync[1];
	assign shift_next = {shift_in[wb_pkg::WB_DAT_W-2:0], sdi_sync[1]};

	// bit counter, cleared whenever csn is high
	always_ff @(posedge clk) begin
		if (reset_i || frame_off) begin
			bit_cnt <= '0;
		end else if (sck_rise && bit_cnt != CNT_W'(FRAME_END)) begin
			bit_cnt <= bit_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (sck_rise) begin
			shift_in <= shift_next;
			if (bit_cnt == CNT_W'(CMD_LAST)) begin
				is_write <= shift_next[wb_pkg::CMD_WRITE_BIT];
			end
		end
	end

	// reads go out right after the address, writes after the data word
	assign issue_rd = sck_rise && !frame_off && !wbm_cyc_o && !is_write &&
		bit_cnt == CNT_W'(ADR_LAST);
	assign issue_wr = sck_rise && !frame_off && !wbm_cyc_o && is_write &&
		bit_cnt == CNT_W'(DAT_LAST);

	always_ff @(posedge clk) begin
		if (sck_rise && !wbm_cyc_o && bit_cnt == CNT_W'(ADR_LAST)) begin
			wbm_adr_o <= shift_next[wb_pkg::WB_ADR_W-1:0];
		end
		if (issue_wr) begin
			wbm_dat_o <= shift_next;
		end
		if (issue_rd || issue_wr) begin
			wbm_we_o <= is_write;
		end
	end

	// full word writes only
	assign wbm_sel_o = '1;

	// one request per frame, stb drops once accepted
	always_ff @(posedge clk) begin
		if (reset_i) begin
			wbm_cyc_o <= 1'b0;
			wbm_stb_o <= 1'b0;
		end else if (issue_rd || issue_wr) begin
			wbm_cyc_o <= 1'b1;
			wbm_stb_o <= 1'b1;
		end else begin
			if (wbm_stb_o && !wbm_stall_i) begin
				wbm_stb_o <= 1'b0;
			end
			if (wbm_ack_i) begin
				wbm_cyc_o <= 1'b0;
			end
		end
	end

	assign data_phase = !is_write && bit_cnt >= CNT_W'(RD_FIRST) &&
		bit_cnt < CNT_W'(FRAME_END);

	// read word lands during the dummy byte
	always_ff @(posedge clk) begin
		if (wbm_cyc_o && wbm_ack_i && !wbm_we_o) begin
			shift_out <= wbm_dat_i;
		end else if (sck_fall && data_phase && !frame_off) begin
			shift_out <= {shift_out[wb_pkg::WB_DAT_W-2:0], 1'b0};
		end
	end

	// mode 0, sdo moves after the falling edge
	always_ff @(posedge clk) begin
		if (reset_i || frame_off) begin
			spi_sdo_o <= 1'b0;
		end else if (sck_fall) begin
			spi_sdo_o <= data_phase ? shift_out[wb_pkg::WB_DAT_W-1] : 1'b0;
		end
	end

endmodule

/* src/wb_pkg.sv */
package wb_pkg;

	// master side of the bus
	localparam int unsigned WB_ADR_W = 16;
	localparam int unsigned WB_DAT_W = 32;
	localparam int unsigned WB_SEL_W = WB_DAT_W / 8;

	// slaves only see the low address bits
	localparam int unsigned SLV_ADR_W = 4;

	// address bits 7..4 pick the peripheral
	// anything above bit 7 is unmapped
	localparam int unsigned PERIPH_LSB = 4;

	// spi command byte, only the write flag matters
	// the remaining bits are don't care
	localparam int unsigned CMD_WRITE_BIT = 7;

	// peripheral slots on the interconnect
	localparam int unsigned PERIPH_RGB = 0;
	localparam int unsigned PERIPH_RAM = 1;

	// rgb controller register map
	localparam logic [SLV_ADR_W-1:0] RGB_REG_R = 4'd0;
	localparam logic [SLV_ADR_W-1:0] RGB_REG_G = 4'd1;
	localparam logic [SLV_ADR_W-1:0] RGB_REG_B = 4'd2;

	// bit 0 gates all three outputs
	localparam logic [SLV_ADR_W-1:0] RGB_REG_CTRL = 4'd3;

endpackage
